//--- verilog.f
src/valu_pkg.sv
src/valu_issue.sv
src/valu_logic_unit.sv
src/valu_addsub.sv
src/valu_mul_unit.sv
src/valu_result_stage.sv
src/valu_top.sv
testbench/valu_checker.sv
testbench/tb_valu.sv

//--- Makefile
# Verilator build and run of the vector ALU testbench

TOP        ?= tb_valu
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
SEED_LOG   ?= sim.log
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(SEED_LOG)
	@grep -qF "$(PASS_MSG)" $(SEED_LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(SEED_LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)

//--- testbench/tb_valu.sv
`timescale 1ns/100ps

module tb_valu import valu_pkg::*; ();

	// Stimulus length and drain bound in cycles
	localparam int N_CYCLES    = 3000;
	localparam int DRAIN_LIMIT = 20;

	logic       clk;
	logic       arst_n;
	logic       in_valid;
	valu_req_t  in_req;
	logic       out_valid;
	valu_resp_t out_resp;

	int   data_errs;
	int   illegal_errs;
	int   valid_errs;
	int   checked;
	int   pending;
	logic timed_out;

	valu_top UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.out_valid (out_valid),
		.out_resp  (out_resp)
	);

	valu_checker u_check (
		.clk          (clk),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.in_req       (in_req),
		.out_valid    (out_valid),
		.out_resp     (out_resp),
		.data_errs    (data_errs),
		.illegal_errs (illegal_errs),
		.valid_errs   (valid_errs),
		.checked      (checked),
		.pending      (pending)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Corner values now and then, to hit every carry kill
	function automatic logic [63:0] random_operand();
		case ($urandom % 8)
			0: random_operand = '1;
			1: random_operand = '0;
			default: random_operand = {$urandom, $urandom};
		endcase
	endfunction

	// About 90% legal R_ALU traffic
	function automatic valu_req_t random_req();
		valu_req_t  r;
		logic [5:0] f;
		r.ww = valu_width_e'(2'($urandom));
		r.ra = random_operand();
		r.rb = random_operand();
		if (($urandom % 10) != 0) begin
			r.op_code = R_ALU;
			// Kept codes 0 to 9, 13, 16 and 17
			do begin
				f = 6'($urandom % 18);
			end while (f inside {[6'd10:6'd12], 6'd14, 6'd15});
			r.r_ins = f;
		end else if (($urandom % 2) != 0) begin
			r.op_code = R_ALU;
			// Dropped or unknown function
			do begin
				f = 6'($urandom);
			end while (f inside {[6'd0:6'd9], 6'd13, 6'd16, 6'd17});
			r.r_ins = f;
		end else begin
			// Any major code except R_ALU
			do begin
				r.op_code = 6'($urandom);
			end while (r.op_code == R_ALU);
			r.r_ins = 6'($urandom);
		end
		return r;
	endfunction

	initial begin
		int t;
		void'($urandom(32'h86f01f27));
		timed_out = 1'b0;
		arst_n    = 1'b0;
		in_valid  = 1'b0;
		in_req    = '0;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		// Random gaps give bubbles and back-to-back runs
		for (int i = 0; i < N_CYCLES; i++) begin
			@(posedge clk);
			#1;
			in_valid = (($urandom % 8) != 0);
			in_req   = random_req();
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		// Let the last two requests come out
		t = 0;
		while (pending != 0 && t < DRAIN_LIMIT) begin
			@(posedge clk);
			t++;
		end
		if (pending != 0) begin
			timed_out = 1'b1;
			$display("Timeout, pipeline did not drain within %0d cycles", DRAIN_LIMIT);
		end
		if (checked == 0) begin
			$display("No responses were checked");
		end
		$display("Checked %0d, errors data %0d illegal %0d valid %0d timeout %0d",
			checked, data_errs, illegal_errs, valid_errs, int'(timed_out));
		if (data_errs == 0 && illegal_errs == 0 && valid_errs == 0 && !timed_out
			&& checked > 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- testbench/valu_checker.sv
`timescale 1ns/100ps

module valu_checker import valu_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       in_valid,
	input  valu_req_t  in_req,
	input  logic       out_valid,
	input  valu_resp_t out_resp,
	output int         data_errs,
	output int         illegal_errs,
	output int         valid_errs,
	output int         checked,
	output int         pending
);

	// Expected responses, slot 1 is the older one
	logic       exp_v0;
	logic       exp_v1;
	valu_resp_t exp_r0;
	valu_resp_t exp_r1;

	// Running counts
	int n_data    = 0;
	int n_illegal = 0;
	int n_valid   = 0;
	int n_checked = 0;
	int n_pending = 0;

	assign data_errs    = n_data;
	assign illegal_errs = n_illegal;
	assign valid_errs   = n_valid;
	assign checked      = n_checked;
	assign pending      = n_pending;

	// Reference model, lane 0 sits at the MSB end
	function automatic valu_resp_t model(valu_req_t r);
		valu_resp_t  e;
		valu_funct_e f;
		int          w;
		int          lsb;
		logic        odd;
		logic [63:0] mask;
		logic [63:0] x;
		logic [63:0] y;
		logic [63:0] s;
		e    = '0;
		f    = valu_funct_e'(r.r_ins);
		w    = 8 << r.ww;
		mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		// Only R_ALU runs here
		if (r.op_code != R_ALU) begin
			e.illegal = 1'b1;
			return e;
		end
		case (f)
			VNOP: e.data = '0;
			VAND: e.data = r.ra & r.rb;
			VOR:  e.data = r.ra | r.rb;
			VXOR: e.data = r.ra ^ r.rb;
			VNOT: e.data = ~r.ra;
			VMOV: e.data = r.ra;
			VADD, VSUB, VRTTH: begin
				// One lane at a time, each wraps on its own
				for (int k = 0; k < 64 / w; k++) begin
					lsb = 64 - w * (k + 1);
					x   = (r.ra >> lsb) & mask;
					y   = (r.rb >> lsb) & mask;
					if (f == VADD) begin
						s = x + y;
					end else if (f == VSUB) begin
						s = x - y;
					end else begin
						// Half swap
						s = (x >> (w / 2)) | (x << (w / 2));
					end
					e.data |= (s & mask) << lsb;
				end
			end
			VMULEU, VMULOU, VSQEU, VSQOU: begin
				if (r.ww == W64) begin
					e.illegal = 1'b1;
				end else begin
					odd = (f == VMULOU) || (f == VSQOU);
					for (int j = 0; j < 32 / w; j++) begin
						// Source lane 2j+odd, product into lane j of width 2w
						lsb = 64 - w * (2 * j + int'(odd) + 1);
						x   = (r.ra >> lsb) & mask;
						if (f == VSQEU || f == VSQOU) begin
							y = x;
						end else begin
							y = (r.rb >> lsb) & mask;
						end
						e.data |= (x * y) << (64 - 2 * w * (j + 1));
					end
				end
			end
			// Shifts, divide, modulo, square root and unknown codes
			default: e.illegal = 1'b1;
		endcase
		return e;
	endfunction

	// Compare on the falling edge, inputs and outputs both settled
	always @(negedge clk) begin
		if (!arst_n) begin
			if (out_valid) begin
				n_valid++;
				$display("out_valid is high during reset at %0t", $time);
			end
			exp_v0 = 1'b0;
			exp_v1 = 1'b0;
		end else begin
			if (exp_v1 && !out_valid) begin
				n_valid++;
				$display("Missing response at %0t, out_valid stayed low", $time);
			end else if (!exp_v1 && out_valid) begin
				n_valid++;
				$display("Unexpected response at %0t with no request two cycles before",
					$time);
			end else if (exp_v1) begin
				n_checked++;
				if (out_resp.data !== exp_r1.data) begin
					n_data++;
					$display("Error out_resp.data expected %h got %h at %0t",
						exp_r1.data, out_resp.data, $time);
				end
				if (out_resp.illegal !== exp_r1.illegal) begin
					n_illegal++;
					$display("Error out_resp.illegal expected %h got %h at %0t",
						exp_r1.illegal, out_resp.illegal, $time);
				end
			end
			// Two stages deep, same as the DUT
			exp_v1 = exp_v0;
			exp_r1 = exp_r0;
			exp_v0 = in_valid;
			exp_r0 = model(in_req);
		end
		n_pending = int'(exp_v0) + int'(exp_v1);
	end

endmodule

//--- src/valu_top.sv
`timescale 1ns/100ps

module valu_top import valu_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       in_valid,
	input  valu_req_t  in_req,
	output logic       out_valid,
	output valu_resp_t out_resp
);

	// Issue stage outputs
	logic        iss_valid;
	valu_issue_t iss;

	// Unit results into the result mux
	logic [VALU_DATA_W-1:0] logic_result;
	logic [VALU_DATA_W-1:0] addsub_result;
	logic [VALU_DATA_W-1:0] mul_result;

	// Stage 1, register and decode
	valu_issue u_issue (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.iss_valid (iss_valid),
		.iss       (iss)
	);

	// Combinational units all see the same issue word
	valu_logic_unit u_logic (
		.iss    (iss),
		.result (logic_result)
	);

	valu_addsub u_addsub (
		.iss    (iss),
		.result (addsub_result)
	);

	valu_mul_unit u_mul (
		.iss    (iss),
		.result (mul_result)
	);

	// Stage 2, select and register
	valu_result_stage u_result (
		.clk           (clk),
		.arst_n        (arst_n),
		.iss_valid     (iss_valid),
		.iss           (iss),
		.logic_result  (logic_result),
		.addsub_result (addsub_result),
		.mul_result    (mul_result),
		.out_valid     (out_valid),
		.out_resp      (out_resp)
	);

endmodule

//--- src/valu_result_stage.sv
`timescale 1ns/100ps

module valu_result_stage import valu_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   iss_valid,
	input  valu_issue_t            iss,
	input  logic [VALU_DATA_W-1:0] logic_result,
	input  logic [VALU_DATA_W-1:0] addsub_result,
	input  logic [VALU_DATA_W-1:0] mul_result,
	output logic                   out_valid,
	output valu_resp_t             out_resp
);

	valu_resp_t resp_next;

	// Unit mux, NONE and illegal give zero
	always_comb begin
		resp_next.illegal = iss.illegal;
		case (iss.unit)
			UNIT_LOGIC:  resp_next.data = logic_result;
			UNIT_ADDSUB: resp_next.data = addsub_result;
			UNIT_MUL:    resp_next.data = mul_result;
			default:     resp_next.data = '0;
		endcase
		if (iss.illegal) begin
			resp_next.data = '0;
		end
	end

	// Response register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			out_resp  <= '0;
		end else begin
			out_valid <= iss_valid;
			if (iss_valid) begin
				out_resp <= resp_next;
			end
		end
	end

	// Fixed one cycle from issue to response
	a_valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
		1'b1 |=> (out_valid == $past(iss_valid)));

	// Illegal decode shows up as a zero response next cycle
	a_illegal_zero: assert property (@(posedge clk) disable iff (!arst_n)
		iss_valid && iss.illegal |=> out_resp.illegal && (out_resp.data == '0));

	// Issue must flag a 64-bit multiply or square
	a_mul_w64: assert property (@(posedge clk) disable iff (!arst_n)
		iss_valid && (iss.unit == UNIT_MUL) && (iss.ww == W64) |-> iss.illegal);

endmodule

//--- src/valu_mul_unit.sv
`timescale 1ns/100ps

module valu_mul_unit import valu_pkg::*; (
	input  valu_issue_t             iss,
	output logic [VALU_DATA_W-1:0] result
);

	logic                   odd;
	logic [VALU_DATA_W-1:0] b_src;

	// Odd lanes for MULOU and SQOU, even otherwise
	assign odd   = iss.funct inside {VMULOU, VSQOU};
	// Squares reuse ra as second factor
	assign b_src = (iss.funct inside {VSQEU, VSQOU}) ? iss.ra : iss.rb;

	// Lane k counts from the MSB end
	// Source lane 2j+odd feeds double width output lane j
	always_comb begin
		result = '0;
		case (iss.ww)
			W8: begin
				// Four 8x8 products
				for (int j = 0; j < 4; j++) begin
					result[63-16*j -: 16] =
						16'(iss.ra[63-8*(2*j+int'(odd)) -: 8])
						* 16'(b_src[63-8*(2*j+int'(odd)) -: 8]);
				end
			end
			W16: begin
				// Two 16x16 products
				for (int j = 0; j < 2; j++) begin
					result[63-32*j -: 32] =
						32'(iss.ra[63-16*(2*j+int'(odd)) -: 16])
						* 32'(b_src[63-16*(2*j+int'(odd)) -: 16]);
				end
			end
			W32: begin
				// Single 32x32 product fills the word
				result = 64'(iss.ra[63-32*int'(odd) -: 32])
					* 64'(b_src[63-32*int'(odd) -: 32]);
			end
			// No 64-bit product, flagged at issue
			W64: result = '0;
			default: result = '0;
		endcase
	end

endmodule

//--- src/valu_addsub.sv
`timescale 1ns/100ps

module valu_addsub import valu_pkg::*; (
	input  valu_issue_t             iss,
	output logic [VALU_DATA_W-1:0] result
);

	// Byte segments of the carry chain
	localparam int SEG_W = 8;
	localparam int SEGS  = VALU_DATA_W / SEG_W;

	logic                   sub;
	logic [VALU_DATA_W-1:0] b_op;
	logic [2:0]             lane_mask;
	logic                   cy;
	logic [SEG_W:0]         seg_sum;

	// Operand prep
	always_comb begin
		sub  = (iss.funct == VSUB);
		// Two's complement subtract, the +1 comes in at each lane start
		b_op = sub ? ~iss.rb : iss.rb;
		// Segment index bits that stay inside one lane
		// W8 none, W16 bit 0, W32 bits 1:0, W64 bits 2:0
		lane_mask = {iss.ww == W64, iss.ww inside {W32, W64}, iss.ww != W8};
	end

	// Ripple across segments LSB first
	always_comb begin
		cy      = 1'b0;
		seg_sum = '0;
		result  = '0;
		for (int s = 0; s < SEGS; s++) begin
			// Lane start, kill incoming carry and inject sub
			if ((3'(s) & lane_mask) == 3'b000) begin
				cy = sub;
			end
			seg_sum = {1'b0, iss.ra[SEG_W*s +: SEG_W]}
				+ {1'b0, b_op[SEG_W*s +: SEG_W]}
				+ (SEG_W+1)'(cy);
			result[SEG_W*s +: SEG_W] = seg_sum[SEG_W-1:0];
			// Carry out, passed on only if the next segment is in the same lane
			cy = seg_sum[SEG_W];
		end
	end

endmodule

//--- src/valu_logic_unit.sv
`timescale 1ns/100ps

module valu_logic_unit import valu_pkg::*; (
	input  valu_issue_t             iss,
	output logic [VALU_DATA_W-1:0] result
);

	logic [VALU_DATA_W-1:0] rtth;

	// Half swap inside every lane of ra
	always_comb begin
		rtth = '0;
		case (iss.ww)
			W8: begin
				// Nibble swap per byte
				for (int i = 0; i < 8; i++) begin
					rtth[8*i +: 8] = {iss.ra[8*i +: 4], iss.ra[8*i+4 +: 4]};
				end
			end
			W16: begin
				for (int i = 0; i < 4; i++) begin
					rtth[16*i +: 16] = {iss.ra[16*i +: 8], iss.ra[16*i+8 +: 8]};
				end
			end
			W32: begin
				for (int i = 0; i < 2; i++) begin
					rtth[32*i +: 32] = {iss.ra[32*i +: 16], iss.ra[32*i+16 +: 16]};
				end
			end
			// Whole word, swap the 32-bit halves
			W64: rtth = {iss.ra[31:0], iss.ra[63:32]};
			default: rtth = '0;
		endcase
	end

	// Function select
	always_comb begin
		case (iss.funct)
			VAND:    result = iss.ra & iss.rb;
			VOR:     result = iss.ra | iss.rb;
			VXOR:    result = iss.ra ^ iss.rb;
			// Unary, rb ignored
			VNOT:    result = ~iss.ra;
			VMOV:    result = iss.ra;
			VRTTH:   result = rtth;
			default: result = '0;
		endcase
	end

endmodule

//--- src/valu_issue.sv
`timescale 1ns/100ps

module valu_issue import valu_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        in_valid,
	input  valu_req_t   in_req,
	output logic        iss_valid,
	output valu_issue_t iss
);

	valu_issue_t  dec;
	valu_opcode_e op;

	// Decode ahead of the issue register
	always_comb begin
		op          = valu_opcode_e'(in_req.op_code);
		dec.funct   = valu_funct_e'(in_req.r_ins);
		dec.ww      = in_req.ww;
		dec.ra      = in_req.ra;
		dec.rb      = in_req.rb;
		dec.unit    = UNIT_NONE;
		dec.illegal = 1'b1;
		case (op)
			R_ALU: begin
				case (dec.funct)
					// Zero result, still a legal request
					VNOP: dec.illegal = 1'b0;
					VAND, VOR, VXOR, VNOT, VMOV, VRTTH: begin
						dec.unit    = UNIT_LOGIC;
						dec.illegal = 1'b0;
					end
					VADD, VSUB: begin
						dec.unit    = UNIT_ADDSUB;
						dec.illegal = 1'b0;
					end
					VMULEU, VMULOU, VSQEU, VSQOU: begin
						dec.unit    = UNIT_MUL;
						// No 64x64 product
						dec.illegal = (dec.ww == W64);
					end
					// Shifts, divide, modulo and square root not built
					VSLL, VSRL, VSRA, VDIV, VMOD, VSQRT: dec.illegal = 1'b1;
					default: dec.illegal = 1'b1;
				endcase
			end
			// Memory, branch and nop codes belong to other stages
			LOAD, STORE, BRANCH_EZ, BRANCH_NZ, NOP: dec.illegal = 1'b1;
			default: dec.illegal = 1'b1;
		endcase
	end

	// Issue register, payload only loads on a valid request
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			iss_valid <= 1'b0;
			iss       <= '0;
		end else begin
			iss_valid <= in_valid;
			if (in_valid) begin
				iss <= dec;
			end
		end
	end

endmodule

//--- src/valu_pkg.sv
package valu_pkg;

	// Operand and result width
	localparam int VALU_DATA_W = 64;
	// Op code and function field width
	localparam int VALU_OP_W = 6;

	// Major op codes, only R_ALU executes in this stage
	typedef enum logic [VALU_OP_W-1:0] {
		LOAD      = 6'b100000,
		STORE     = 6'b100001,
		BRANCH_EZ = 6'b100010,
		BRANCH_NZ = 6'b100011,
		R_ALU     = 6'b101010,
		NOP       = 6'b111100
	} valu_opcode_e;

	// R-type function codes
	typedef enum logic [VALU_OP_W-1:0] {
		VNOP   = 6'd0,
		VAND   = 6'd1,
		VOR    = 6'd2,
		VXOR   = 6'd3,
		VNOT   = 6'd4,
		VMOV   = 6'd5,
		VADD   = 6'd6,
		VSUB   = 6'd7,
		VMULEU = 6'd8,
		VMULOU = 6'd9,
		VSLL   = 6'd10,
		VSRL   = 6'd11,
		VSRA   = 6'd12,
		VRTTH  = 6'd13,
		VDIV   = 6'd14,
		VMOD   = 6'd15,
		VSQEU  = 6'd16,
		VSQOU  = 6'd17,
		VSQRT  = 6'd18
	} valu_funct_e;

	// Lane width from the WW field
	typedef enum logic [1:0] {
		W8  = 2'b00,
		W16 = 2'b01,
		W32 = 2'b10,
		W64 = 2'b11
	} valu_width_e;

	// Compute unit steering
	typedef enum logic [1:0] {
		UNIT_NONE,
		UNIT_LOGIC,
		UNIT_ADDSUB,
		UNIT_MUL
	} valu_unit_e;

	// Raw request, code fields kept as plain instruction bits
	typedef struct packed {
		logic [VALU_OP_W-1:0]   op_code;
		logic [VALU_OP_W-1:0]   r_ins;
		valu_width_e            ww;
		logic [VALU_DATA_W-1:0] ra;
		logic [VALU_DATA_W-1:0] rb;
	} valu_req_t;

	// Decoded request
	typedef struct packed {
		valu_funct_e            funct;
		valu_width_e            ww;
		logic [VALU_DATA_W-1:0] ra;
		logic [VALU_DATA_W-1:0] rb;
		valu_unit_e             unit;
		logic                   illegal;
	} valu_issue_t;

	typedef struct packed {
		logic [VALU_DATA_W-1:0] data;
		logic                   illegal;
	} valu_resp_t;

endpackage
